// ==== design/mult_share_pkg.sv ====
// shared widths, types and encodings for the multiplier sharing design.
package mult_share_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes.
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_CLIENTS = 3;   // client streams at the top level.
  localparam int OPND_W      = 16;  // width of one multiplier operand.
  localparam int DAT_W       = 2 * OPND_W;  // a stream word holds two operands or one product.
  localparam int CTL_W       = 8;   // width of the control word that rides with each beat.
  localparam int MULT_STAGES = 3;   // register stages inside the multiplier.

  // the client number sits at the bottom of the control word.
  localparam int SRC_LSB = 0;
  localparam int SRC_W   = 2;

  // the client's own tag fills everything above the client number.
  localparam int TAG_LSB = SRC_LSB + SRC_W;
  localparam int TAG_W   = CTL_W - TAG_LSB;

  ////////////////////////////////////////////////////////////////////////////
  // types.
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [OPND_W-1:0] opnd_t;  // one unsigned operand.

  // a request word is {a, b}; a response word is the unsigned product a * b.
  typedef logic [DAT_W-1:0] dat_t;

  typedef logic [CTL_W-1:0] ctl_t;    // control word, {tag, client number}.
  typedef logic [SRC_W-1:0] src_t;    // client number written by the arbiter.
  typedef logic [TAG_W-1:0] tag_t;    // free tag owned by the client.

  // the arbiter is either looking for a new packet or locked onto one client.
  typedef enum logic {
    ARB_IDLE   = 1'b0,  // no packet open; next sop beat wins in round-robin order.
    ARB_LOCKED = 1'b1   // a packet is open; only the granted client may send.
  } arb_state_e;

endpackage

// ==== design/if_stream.sv ====
`timescale 1ns/10ps

// valid/ready stream with packet framing.
// a beat moves on a rising clock edge when val and rdy are both high.
// the source keeps everything steady while val is high and rdy is low.
interface if_stream
  import mult_share_pkg::*;
();

  dat_t dat;   // payload word.
  ctl_t ctl;   // control word that travels with the payload.
  logic val;   // source has a beat on the bus.
  logic rdy;   // sink takes the beat this cycle.
  logic sop;   // first beat of a packet.
  logic eop;   // last beat of a packet; both flags are set on a single-beat packet.

  // the side that produces beats.
  modport source (
    output dat,
    output ctl,
    output val,
    output sop,
    output eop,
    input  rdy
  );

  // the side that consumes beats.
  modport sink (
    input  dat,
    input  ctl,
    input  val,
    input  sop,
    input  eop,
    output rdy
  );

endinterface

// ==== design/packet_arb.sv ====
`timescale 1ns/10ps

// round-robin arbiter that picks whole packets from NUM_IN streams.
// the winner keeps the grant until its eop beat is taken, so packets never interleave.
// the chosen client's number is written into the control word on the way out.
module packet_arb
  import mult_share_pkg::*;
#(
  parameter int NUM_IN = 2
) (
  input  logic     i_clk,
  input  logic     i_rst_n,
  if_stream.sink   i_req [NUM_IN-1:0],
  if_stream.source o_req
);

  typedef logic [$clog2(NUM_IN)-1:0] idx_t;  // wide enough to name every input.

  logic [NUM_IN-1:0] req_val;  // flattened copies of the input streams.
  logic [NUM_IN-1:0] req_sop;
  logic [NUM_IN-1:0] req_eop;
  logic [NUM_IN-1:0] req_rdy;
  dat_t              req_dat [NUM_IN];
  ctl_t              req_ctl [NUM_IN];

  arb_state_e state_q;    // idle or locked on a packet.
  idx_t       ptr_q;      // first client to look at on the next packet.
  idx_t       grant_q;    // client that owns the open packet.
  idx_t       sel;        // round-robin winner among clients showing sop.
  idx_t       cur;        // client served this cycle.
  logic       found;      // some client is offering a sop beat.
  logic       has_grant;  // cur really owns the output this cycle.
  logic       out_free;   // output register is empty or drained this cycle.
  logic       acc;        // a beat is taken from cur this cycle.
  logic       run_q;      // low during reset and the cycle after, keeps every rdy low.
  ctl_t       ctl_stamp;  // control word of cur with its client number written in.

  // step to the next client, wrapping at NUM_IN.
  function automatic idx_t next_idx(input idx_t v);
    return (int'(v) == NUM_IN - 1) ? '0 : idx_t'(v + 1'b1);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // flatten the interface array so it can be indexed by a signal.
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_IN; g++) begin : g_flat
    assign req_val[g]    = i_req[g].val;
    assign req_sop[g]    = i_req[g].sop;
    assign req_eop[g]    = i_req[g].eop;
    assign req_dat[g]    = i_req[g].dat;
    assign req_ctl[g]    = i_req[g].ctl;
    assign i_req[g].rdy  = req_rdy[g];  // only the served client sees rdy.
  end

  ////////////////////////////////////////////////////////////////////////////
  // grant selection.
  ////////////////////////////////////////////////////////////////////////////

  // scan once around the ring starting at ptr_q and keep the first sop offer.
  always_comb begin
    idx_t cand;
    cand  = ptr_q;
    found = 1'b0;
    sel   = ptr_q;
    for (int i = 0; i < NUM_IN; i++) begin
      if (!found && req_val[cand] && req_sop[cand]) begin
        found = 1'b1;
        sel   = cand;
      end
      cand = next_idx(cand);
    end
  end

  assign has_grant = (state_q == ARB_LOCKED) || found;     // locked always serves its owner.
  assign cur       = (state_q == ARB_LOCKED) ? grant_q : sel;
  assign out_free  = !o_req.val || o_req.rdy;               // room for a new beat next edge.

  always_comb begin
    req_rdy = '0;
    if (run_q && has_grant && out_free) req_rdy[cur] = 1'b1;
  end

  assign acc = req_val[cur] && req_rdy[cur];

  always_comb begin
    ctl_stamp                      = req_ctl[cur];
    ctl_stamp[SRC_LSB +: SRC_W]    = src_t'(cur);  // result demux routes on this field.
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and output register.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q   <= ARB_IDLE;
      ptr_q     <= '0;             // client 0 is first in line after reset.
      grant_q   <= '0;
      run_q     <= 1'b0;
      o_req.val <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (out_free) o_req.val <= acc;  // refill or empty the output slot.
      if (acc) begin
        grant_q <= cur;
        state_q <= req_eop[cur] ? ARB_IDLE : ARB_LOCKED;  // eop closes the packet.
        if (state_q == ARB_IDLE) ptr_q <= next_idx(cur);  // winner goes to the back.
      end
    end
  end

  // payload only moves on an accepted beat, val above says whether it means anything.
  always_ff @(posedge i_clk) begin
    if (acc) begin
      o_req.dat <= req_dat[cur];
      o_req.ctl <= ctl_stamp;
      o_req.sop <= req_sop[cur];
      o_req.eop <= req_eop[cur];
    end
  end

endmodule

// ==== design/resource_share.sv ====
`timescale 1ns/10ps

// shares one pipelined resource among NUM_IN request streams.
// requests go out through the packet arbiter, which stamps the client number.
// results come back and are steered to the client named in their control word.
module resource_share
  import mult_share_pkg::*;
#(
  parameter int NUM_IN = 2
) (
  input  logic     i_clk,
  input  logic     i_rst_n,
  if_stream.sink   i_req [NUM_IN-1:0],  // client requests.
  if_stream.source o_res,               // merged requests to the resource.
  if_stream.sink   i_res,               // results from the resource.
  if_stream.source o_rsp [NUM_IN-1:0]   // results back to the clients.
);

  src_t              res_src;  // client that owns the current result beat.
  ctl_t              rsp_ctl;  // result control word with the client number cleared.
  logic [NUM_IN-1:0] rsp_rdy;  // flattened client rdy lines.

  ////////////////////////////////////////////////////////////////////////////
  // request side.
  ////////////////////////////////////////////////////////////////////////////

  packet_arb #(
    .NUM_IN ( NUM_IN )
  ) u_packet_arb (
    .i_clk   ( i_clk   ),
    .i_rst_n ( i_rst_n ),
    .i_req   ( i_req   ),
    .o_req   ( o_res   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // result demux, purely combinational.
  ////////////////////////////////////////////////////////////////////////////

  assign res_src = i_res.ctl[SRC_LSB +: SRC_W];

  always_comb begin
    rsp_ctl                   = i_res.ctl;
    rsp_ctl[SRC_LSB +: SRC_W] = '0;  // clients never see the routing field.
  end

  for (genvar g = 0; g < NUM_IN; g++) begin : g_demux
    assign o_rsp[g].val = i_res.val && (res_src == src_t'(g));  // only the owner sees val.
    assign o_rsp[g].dat = i_res.dat;
    assign o_rsp[g].ctl = rsp_ctl;
    assign o_rsp[g].sop = i_res.sop;
    assign o_rsp[g].eop = i_res.eop;
    assign rsp_rdy[g]   = o_rsp[g].rdy;
  end

  // the owner's rdy goes back to the resource, a number with no client stalls it.
  assign i_res.rdy = (int'(res_src) < NUM_IN) ? rsp_rdy[res_src] : 1'b0;

endmodule

// ==== design/shared_mult.sv ====
`timescale 1ns/10ps

// three-stage unsigned 16 by 16 multiplier on a valid/ready stream.
// stage 0 registers the operands, stage 1 the raw product, stage 2 drives the output.
// control, sop and eop ride in step with each beat.
module shared_mult
  import mult_share_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst_n,
  if_stream.sink   i_opnd,  // {a, b} operand pairs.
  if_stream.source o_prod   // products a * b.
);

  logic [MULT_STAGES-1:0] vld_q;   // one valid flag per stage, bit 0 is the first stage.
  logic [MULT_STAGES-1:0] sop_q;   // framing carried beside the data.
  logic [MULT_STAGES-1:0] eop_q;
  ctl_t                   ctl_q [MULT_STAGES];
  logic                   adv;     // whole pipeline moves one step this cycle.
  opnd_t                  a_q;     // stage 0 operands.
  opnd_t                  b_q;
  dat_t                   prod1_q; // stage 1 product.
  dat_t                   prod2_q; // stage 2 product, feeds the output.

  ////////////////////////////////////////////////////////////////////////////
  // flow control.
  ////////////////////////////////////////////////////////////////////////////

  // a stalled full output holds every stage; a bubble at the end lets it close up.
  assign adv        = o_prod.rdy || !vld_q[MULT_STAGES-1];
  assign i_opnd.rdy = adv;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      vld_q <= '0;
    end else if (adv) begin
      vld_q <= {vld_q[MULT_STAGES-2:0], i_opnd.val};  // an input beat enters when adv is high.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // data path.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (adv) begin
      a_q     <= opnd_t'(i_opnd.dat[DAT_W-1 -: OPND_W]);  // operand a is the upper half.
      b_q     <= opnd_t'(i_opnd.dat[OPND_W-1:0]);         // operand b is the lower half.
      prod1_q <= dat_t'(a_q) * dat_t'(b_q);               // full 32-bit unsigned product.
      prod2_q <= prod1_q;
    end
  end

  // sideband shift register, same enable as the data.
  always_ff @(posedge i_clk) begin
    if (adv) begin
      ctl_q[0] <= i_opnd.ctl;
      for (int s = 1; s < MULT_STAGES; s++) begin
        ctl_q[s] <= ctl_q[s-1];
      end
      sop_q <= {sop_q[MULT_STAGES-2:0], i_opnd.sop};
      eop_q <= {eop_q[MULT_STAGES-2:0], i_opnd.eop};
    end
  end

  assign o_prod.val = vld_q[MULT_STAGES-1];
  assign o_prod.dat = prod2_q;
  assign o_prod.ctl = ctl_q[MULT_STAGES-1];  // still holds the client number for the demux.
  assign o_prod.sop = sop_q[MULT_STAGES-1];
  assign o_prod.eop = eop_q[MULT_STAGES-1];

endmodule

// ==== design/mult_share_top.sv ====
`timescale 1ns/10ps

// three clients share one multiplier.
// requests are merged packet by packet, multiplied, and the products are sent back
// to the client that asked for them with the client's tag intact.
module mult_share_top
  import mult_share_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,

  // client requests, one bit or entry per client.
  input  logic [NUM_CLIENTS-1:0] i_req_val,
  input  logic [NUM_CLIENTS-1:0] i_req_sop,
  input  logic [NUM_CLIENTS-1:0] i_req_eop,
  input  dat_t                   i_req_dat [NUM_CLIENTS],  // {a, b}.
  input  tag_t                   i_req_tag [NUM_CLIENTS],  // returned unchanged with the result.
  output logic [NUM_CLIENTS-1:0] o_req_rdy,

  // client results.
  output logic [NUM_CLIENTS-1:0] o_rsp_val,
  output logic [NUM_CLIENTS-1:0] o_rsp_sop,
  output logic [NUM_CLIENTS-1:0] o_rsp_eop,
  output dat_t                   o_rsp_dat [NUM_CLIENTS],  // a * b.
  output tag_t                   o_rsp_tag [NUM_CLIENTS],
  input  logic [NUM_CLIENTS-1:0] i_rsp_rdy
);

  ////////////////////////////////////////////////////////////////////////////
  // stream interfaces.
  ////////////////////////////////////////////////////////////////////////////

  if_stream req_if [NUM_CLIENTS-1:0] ();  // one request stream per client.
  if_stream rsp_if [NUM_CLIENTS-1:0] ();  // one result stream per client.
  if_stream mult_in_if ();                // arbiter to multiplier.
  if_stream mult_out_if ();               // multiplier back to the demux.

  ////////////////////////////////////////////////////////////////////////////
  // plain ports onto the interfaces and back.
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_CLIENTS; g++) begin : g_client
    assign req_if[g].val = i_req_val[g];
    assign req_if[g].sop = i_req_sop[g];
    assign req_if[g].eop = i_req_eop[g];
    assign req_if[g].dat = i_req_dat[g];
    // tag goes above the client number field, which starts out as zero.
    assign req_if[g].ctl = ctl_t'({i_req_tag[g], {TAG_LSB{1'b0}}});
    assign o_req_rdy[g]  = req_if[g].rdy;

    assign o_rsp_val[g]  = rsp_if[g].val;
    assign o_rsp_sop[g]  = rsp_if[g].sop;
    assign o_rsp_eop[g]  = rsp_if[g].eop;
    assign o_rsp_dat[g]  = rsp_if[g].dat;
    assign o_rsp_tag[g]  = rsp_if[g].ctl[TAG_LSB +: TAG_W];  // only the tag leaves the chip.
    assign rsp_if[g].rdy = i_rsp_rdy[g];
  end

  ////////////////////////////////////////////////////////////////////////////
  // sharing logic around the multiplier.
  ////////////////////////////////////////////////////////////////////////////

  // arbiter on the way in, demux on the way out.
  resource_share #(
    .NUM_IN ( NUM_CLIENTS )
  ) u_resource_share (
    .i_clk   ( i_clk       ),
    .i_rst_n ( i_rst_n     ),
    .i_req   ( req_if      ),
    .o_res   ( mult_in_if  ),
    .i_res   ( mult_out_if ),
    .o_rsp   ( rsp_if      )
  );

  // one cycle in the arbiter plus MULT_STAGES here gives four cycles end to end.
  shared_mult u_shared_mult (
    .i_clk   ( i_clk       ),
    .i_rst_n ( i_rst_n     ),
    .i_opnd  ( mult_in_if  ),
    .o_prod  ( mult_out_if )
  );

endmodule

// ==== bench/mult_share_checker.sv ====
`timescale 1ns/10ps

// watches the top level ports and checks the sharing rules with assertions.
// every failure bumps fail_cnt, which the testbench reads at the end.
module mult_share_checker
  import mult_share_pkg::*;
(
  input logic                   i_clk,
  input logic                   i_rst_n,
  input logic [NUM_CLIENTS-1:0] i_req_val,
  input logic [NUM_CLIENTS-1:0] i_req_sop,
  input logic [NUM_CLIENTS-1:0] i_req_eop,
  input dat_t                   i_req_dat [NUM_CLIENTS],
  input tag_t                   i_req_tag [NUM_CLIENTS],
  input logic [NUM_CLIENTS-1:0] o_req_rdy,
  input logic [NUM_CLIENTS-1:0] o_rsp_val,
  input logic [NUM_CLIENTS-1:0] o_rsp_sop,
  input logic [NUM_CLIENTS-1:0] o_rsp_eop,
  input dat_t                   o_rsp_dat [NUM_CLIENTS],
  input tag_t                   o_rsp_tag [NUM_CLIENTS],
  input logic [NUM_CLIENTS-1:0] i_rsp_rdy
);

  localparam int DEPTH = 8;  // more than the arbiter slot plus the pipeline can hold.

  dat_t                   exp_dat [NUM_CLIENTS][DEPTH];  // expected product per request.
  tag_t                   exp_tag [NUM_CLIENTS][DEPTH];
  logic [1:0]             exp_frm [NUM_CLIENTS][DEPTH];  // {sop, eop} of the request.
  logic [2:0]             wr_q    [NUM_CLIENTS];
  logic [2:0]             rd_q    [NUM_CLIENTS];
  logic [3:0]             cnt_q   [NUM_CLIENTS];         // outstanding requests per client.
  logic [NUM_CLIENTS-1:0] req_acc;
  logic [NUM_CLIENTS-1:0] rsp_acc;
  logic                   open_v_q = 1'b0;  // some packet is open on the request side.
  logic [1:0]             open_c_q = '0;    // client owning that packet.
  logic                   rst_d_q  = 1'b0;  // reset as seen one edge ago.
  logic                   live_q   = 1'b0;  // first edge has passed.
  int unsigned            outstanding;
  int unsigned            fail_cnt = 0;

  assign req_acc = i_req_val & o_req_rdy;
  assign rsp_acc = o_rsp_val & i_rsp_rdy;

  always_comb begin
    outstanding = 0;
    for (int c = 0; c < NUM_CLIENTS; c++) outstanding += cnt_q[c];  // total in flight.
  end

  ////////////////////////////////////////////////////////////////////////////
  // scoreboard, one fifo of expected results per client.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    rst_d_q <= i_rst_n;
    live_q  <= 1'b1;
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      if (!i_rst_n) begin
        wr_q[c]  <= '0;
        rd_q[c]  <= '0;
        cnt_q[c] <= '0;
      end else begin
        if (req_acc[c]) begin
          // result is a times b, a in the upper half of the request word.
          exp_dat[c][wr_q[c]] <= dat_t'(i_req_dat[c][31:16]) * dat_t'(i_req_dat[c][15:0]);
          exp_tag[c][wr_q[c]] <= i_req_tag[c];
          exp_frm[c][wr_q[c]] <= {i_req_sop[c], i_req_eop[c]};
          wr_q[c]             <= wr_q[c] + 1'b1;
        end
        if (rsp_acc[c]) rd_q[c] <= rd_q[c] + 1'b1;
        cnt_q[c] <= cnt_q[c] + 4'(req_acc[c]) - 4'(rsp_acc[c]);
        if (req_acc[c]) begin
          open_v_q <= !i_req_eop[c];  // the eop beat closes the packet.
          open_c_q <= 2'(c);
        end
      end
    end
    if (!i_rst_n) open_v_q <= 1'b0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // protocol and data properties.
  ////////////////////////////////////////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge i_clk)
    (live_q && (!i_rst_n || !rst_d_q)) |-> (o_req_rdy == '0 && o_rsp_val == '0))
    else begin fail_cnt++; $error("ready or result valid high during or right after reset"); end

  a_no_interleave: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    open_v_q |-> (req_acc & ~(NUM_CLIENTS'(1) << open_c_q)) == '0)
    else begin fail_cnt++; $error("request of another client accepted inside an open packet"); end

  for (genvar c = 0; c < NUM_CLIENTS; c++) begin : g_client
    a_routed: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_rsp_val[c] |-> cnt_q[c] != 0)
      else begin fail_cnt++; $error("result on client %0d with nothing outstanding", c); end

    a_dat: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_rsp_val[c] && cnt_q[c] != 0) |-> o_rsp_dat[c] == exp_dat[c][rd_q[c]])
      else begin
        fail_cnt++;
        $error("Error: o_rsp_dat[%0d] = %h, expected %h", c, $sampled(o_rsp_dat[c]),
               $sampled(exp_dat[c][rd_q[c]]));
      end

    a_tag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_rsp_val[c] && cnt_q[c] != 0) |-> o_rsp_tag[c] == exp_tag[c][rd_q[c]])
      else begin
        fail_cnt++;
        $error("Error: o_rsp_tag[%0d] = %h, expected %h", c, $sampled(o_rsp_tag[c]),
               $sampled(exp_tag[c][rd_q[c]]));
      end

    a_frame: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_rsp_val[c] && cnt_q[c] != 0) |-> {o_rsp_sop[c], o_rsp_eop[c]} == exp_frm[c][rd_q[c]])
      else begin
        fail_cnt++;
        $error("Error: o_rsp_sop/eop[%0d] = %h, expected %h", c,
               $sampled({o_rsp_sop[c], o_rsp_eop[c]}), $sampled(exp_frm[c][rd_q[c]]));
      end

    // a stalled result beat may not change.
    a_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_rsp_val[c] && !i_rsp_rdy[c]) |=> (o_rsp_val[c] && $stable(o_rsp_dat[c]) &&
        $stable(o_rsp_tag[c]) && $stable(o_rsp_sop[c]) && $stable(o_rsp_eop[c])))
      else begin fail_cnt++; $error("stalled result on client %0d changed", c); end

    a_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (req_acc[c] && outstanding == 0 && (&i_rsp_rdy)) |-> ##4 o_rsp_val[c])
      else begin fail_cnt++; $error("result on client %0d not seen four cycles after request", c); end
  end

endmodule

bind mult_share_top mult_share_checker u_checker (.*);

// ==== bench/mult_share_tb.sv ====
`timescale 1ns/10ps

module mult_share_tb;
  import mult_share_pkg::*;

  localparam time         CLK_PERIOD    = 100ns;
  localparam int          ACC_TIMEOUT   = 200;  // cycles a beat may wait for rdy.
  localparam int          DRAIN_TIMEOUT = 400;  // cycles to empty the pipeline.
  localparam int          NUM_PKTS      = 16;   // random packets per client.
  localparam int unsigned SEED          = 32'hbb45;

  logic                   i_clk;
  logic                   i_rst_n;
  logic [NUM_CLIENTS-1:0] i_req_val;
  logic [NUM_CLIENTS-1:0] i_req_sop;
  logic [NUM_CLIENTS-1:0] i_req_eop;
  dat_t                   i_req_dat [NUM_CLIENTS];
  tag_t                   i_req_tag [NUM_CLIENTS];
  logic [NUM_CLIENTS-1:0] o_req_rdy;
  logic [NUM_CLIENTS-1:0] o_rsp_val;
  logic [NUM_CLIENTS-1:0] o_rsp_sop;
  logic [NUM_CLIENTS-1:0] o_rsp_eop;
  dat_t                   o_rsp_dat [NUM_CLIENTS];
  tag_t                   o_rsp_tag [NUM_CLIENTS];
  logic [NUM_CLIENTS-1:0] i_rsp_rdy;
  bit                     bp_on;     // random back-pressure on the result side.
  int unsigned            timeouts;  // waits that ran out.

  mult_share_top dut_i (.*);

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // result rdy is low about one cycle in four while back-pressure is on.
  always @(negedge i_clk) begin
    for (int c = 0; c < NUM_CLIENTS; c++) i_rsp_rdy[c] = bp_on ? (($urandom % 4) != 0) : 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // client stimulus.
  ////////////////////////////////////////////////////////////////////////////

  // sends one packet of len beats; called and returns on a falling edge.
  task automatic send_packet(input int c, input int len, output bit ok);
    int waited;
    bit taken;
    ok = 1'b1;
    for (int b = 0; b < len; b++) begin
      i_req_val[c] = 1'b1;
      i_req_sop[c] = (b == 0);
      i_req_eop[c] = (b == len - 1);
      i_req_dat[c] = dat_t'($urandom);
      i_req_tag[c] = tag_t'($urandom);
      taken  = 1'b0;
      waited = 0;
      while (!taken && waited < ACC_TIMEOUT) begin
        #1;
        taken = o_req_rdy[c];  // settled well before the rising edge.
        @(negedge i_clk);
        waited++;
      end
      if (!taken) begin
        $display("client %0d: request beat not accepted within %0d cycles", c, ACC_TIMEOUT);
        timeouts++;
        i_req_val[c] = 1'b0;
        ok = 1'b0;
        return;
      end
    end
    i_req_val[c] = 1'b0;
  endtask

  task automatic run_client(input int c);
    bit ok;
    for (int p = 0; p < NUM_PKTS; p++) begin
      repeat ($urandom % 4) @(negedge i_clk);  // idle gap between packets.
      send_packet(c, 1 + ($urandom % 4), ok);
      if (!ok) return;
    end
  endtask

  // waits until the checker has no request left in flight.
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (dut_i.u_checker.outstanding != 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge i_clk);
      waited++;
    end
    if (dut_i.u_checker.outstanding != 0) begin
      $display("results still outstanding after %0d cycles", DRAIN_TIMEOUT);
      timeouts++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence.
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned errs;
    bit          ok;
    void'($urandom(SEED));
    i_clk     = 1'b0;
    i_rst_n   = 1'b0;
    // every client offers a single-beat packet across reset and the first cycle after it.
    i_req_val = '1;
    i_req_sop = '1;
    i_req_eop = '1;
    i_rsp_rdy = '1;
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      i_req_dat[c] = '0;
      i_req_tag[c] = '0;
    end
    bp_on    = 1'b0;
    timeouts = 0;
    repeat (4) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    i_req_val = '0;
    i_req_sop = '0;
    i_req_eop = '0;

    // lone single beats into an empty pipeline show the bare latency.
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      send_packet(c, 1, ok);
      wait_drain();
    end

    // all clients at once, with back-pressure.
    bp_on = 1'b1;
    fork
      run_client(0);
      run_client(1);
      run_client(2);
    join
    bp_on = 1'b0;
    wait_drain();

    errs = dut_i.u_checker.fail_cnt + timeouts;
    $display("error counts: %0d assertion failures, %0d timeouts",
             dut_i.u_checker.fail_cnt, timeouts);
    if (errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== mult_share.f ====
design/mult_share_pkg.sv
design/if_stream.sv
design/packet_arb.sv
design/resource_share.sv
design/shared_mult.sv
design/mult_share_top.sv
bench/mult_share_checker.sv
bench/mult_share_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the multiplier sharing testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module mult_share_tb -Mdir obj_dir -f mult_share.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vmult_share_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
